// File: Bender.yml
package:
  name: looper_tester

sources:
  - verilog/tester_pkg.sv
  - verilog/uart_rx.sv
  - verilog/uart_tx.sv
  - verilog/mmu.sv
  - verilog/program_mem.sv
  - verilog/looper_tester.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_looper_tester.sv

// File: all.f
+incdir+include
verilog/tester_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/mmu.sv
verilog/program_mem.sv
verilog/looper_tester.sv
test/tb_looper_tester.sv

// File: include/tb_uart_tasks.svh
`ifndef TB_UART_TASKS_SVH
`define TB_UART_TASKS_SVH

// Drives one 8N1 frame onto rxd, line changes on falling clock edges
task automatic uart_send_byte(input logic [7:0]  data,
                              input int unsigned base,
                              input logic [1:0]  cfg);
   int unsigned period;
   int          i;
   period = tester_pkg::bit_period(base, cfg);
   @(negedge clk_100mhz_buf);
   rxd = 1'b0;
   repeat (period) @(negedge clk_100mhz_buf);
   for (i = 0; i < 8; i++) begin
      rxd = data[i];
      repeat (period) @(negedge clk_100mhz_buf);
   end
   rxd = 1'b1;
   repeat (period) @(negedge clk_100mhz_buf);
endtask

// Captures one frame from txd and returns in the middle of its stop bit
task automatic uart_recv_byte(output logic [7:0]  data,
                              input  int unsigned base,
                              input  logic [1:0]  cfg);
   int unsigned period;
   int unsigned waited;
   int          i;
   period = tester_pkg::bit_period(base, cfg);
   waited = 0;
   data   = '0;
   while (txd !== 1'b0) begin
      if (waited >= 12 * period) begin
         $display("No start bit on txd within 12 bit periods of the expected reply");
         $display("Simulation FAILED");
         $fatal(1);
      end
      @(negedge clk_100mhz_buf);
      waited++;
   end
   // Middle of the start bit, then one bit period per sample
   repeat (period / 2) @(negedge clk_100mhz_buf);
   for (i = 0; i < 8; i++) begin
      repeat (period) @(negedge clk_100mhz_buf);
      data[i] = txd;
   end
   repeat (period) @(negedge clk_100mhz_buf);
   if (txd !== 1'b1) begin
      $display("Stop bit on txd was low");
      $display("Simulation FAILED");
      $fatal(1);
   end
endtask

`endif

// File: test/tb_looper_tester.sv
`timescale 1ns/1ps

module tb_looper_tester;

   import tester_pkg::*;

   localparam int unsigned BAUD_BASE     = 8;
   localparam int unsigned HEARTBEAT_BIT = 4;
   localparam int          NUM_WRITES    = 4;
   localparam int          NUM_IGNORED   = 3;
   // Serial frames per baud setting, each command is 11 frames
   localparam int          FRAMES_PER_CFG = 11 * (2 * NUM_WRITES + 4) + NUM_IGNORED;
   localparam int          NUM_FRAMES     = 4 * FRAMES_PER_CFG;

   logic       clk_100mhz_buf;
   logic       rst_n;
   logic       rxd;
   logic [1:0] br_cfg;
   logic       txd;
   mmu_state_t state;
   logic       gpio_led_1;

   // Reference model of the program memory
   word_t      model [mem_addr_t];
   mem_addr_t  written [$];

   `include "tb_uart_tasks.svh"

   looper_tester #(
      .BAUD_BASE    (BAUD_BASE),
      .HEARTBEAT_BIT(HEARTBEAT_BIT)
   ) i_looper_tester (
      .clk_100mhz_buf(clk_100mhz_buf),
      .rst_n         (rst_n),
      .rxd           (rxd),
      .br_cfg        (br_cfg),
      .txd           (txd),
      .state         (state),
      .gpio_led_1    (gpio_led_1)
   );

   initial begin
      clk_100mhz_buf = 1'b0;
      forever #5 clk_100mhz_buf = ~clk_100mhz_buf;
   end

   //////////////////////////////////////////////////////////////////////
   // Checking helpers
   //////////////////////////////////////////////////////////////////////

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (actual !== expected) begin
         $display("FAIL %s expected %0h actual %0h", name, expected, actual);
         $display("Simulation FAILED");
         $fatal(1);
      end
   endtask

   // LED stays low for one half period, then toggles every half period
   function automatic logic hb_expected(input int k);
      int half;
      half = 1 << HEARTBEAT_BIT;
      if (k <= half) begin
         return 1'b0;
      end
      // Even numbered half periods after the first one are high
      return (((k - half - 1) / half) % 2) == 0;
   endfunction

   task automatic check_heartbeat(input int cycles);
      int k;
      for (k = 0; k < cycles; k++) begin
         check_value("heartbeat", hb_expected(k), gpio_led_1);
         @(negedge clk_100mhz_buf);
      end
   endtask

   task automatic wait_idle(input string name);
      int unsigned limit;
      int unsigned n;
      limit = 4 * bit_period(BAUD_BASE, br_cfg);
      n     = 0;
      while (state !== ST_IDLE) begin
         if (n >= limit) begin
            $display("Decoder did not return to idle after the %s command", name);
            $display("Simulation FAILED");
            $fatal(1);
         end
         @(negedge clk_100mhz_buf);
         n++;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Command drivers
   //////////////////////////////////////////////////////////////////////

   task automatic write_word(input mem_addr_t addr, input word_t data);
      logic [1:0] top;
      int         i;
      // Top address bits are don't care
      top = 2'($urandom);
      uart_send_byte(CMD_WRITE, BAUD_BASE, br_cfg);
      uart_send_byte({top, addr[13:8]}, BAUD_BASE, br_cfg);
      uart_send_byte(addr[7:0], BAUD_BASE, br_cfg);
      for (i = WORD_BYTES - 1; i >= 0; i--) begin
         uart_send_byte(data[i*8 +: 8], BAUD_BASE, br_cfg);
      end
      wait_idle("write");
      model[addr] = data;
   endtask

   task automatic read_check(input mem_addr_t addr, input string name);
      logic [1:0] top;
      logic [7:0] rx_byte;
      word_t      got;
      int         i;
      top = 2'($urandom);
      got = '0;
      uart_send_byte(CMD_READ, BAUD_BASE, br_cfg);
      uart_send_byte({top, addr[13:8]}, BAUD_BASE, br_cfg);
      // Reply can begin before the low address frame has ended
      fork
         uart_send_byte(addr[7:0], BAUD_BASE, br_cfg);
         begin
            for (i = 0; i < WORD_BYTES; i++) begin
               uart_recv_byte(rx_byte, BAUD_BASE, br_cfg);
               got = {got[55:0], rx_byte};
            end
         end
      join
      wait_idle("read");
      check_value(name, model[addr], got);
   endtask

   task automatic watch_quiet(input int unsigned cycles);
      int unsigned n;
      for (n = 0; n < cycles; n++) begin
         @(negedge clk_100mhz_buf);
         check_value("ignored byte txd", 1'b1, txd);
         check_value("ignored byte state", ST_IDLE, state);
      end
   endtask

   task automatic send_ignored(input byte_t data);
      fork
         uart_send_byte(data, BAUD_BASE, br_cfg);
         watch_quiet(11 * bit_period(BAUD_BASE, br_cfg));
      join
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      int          cfg;
      int          i;
      int unsigned seed_val;
      mem_addr_t   addr;
      byte_t       junk;
      rst_n    = 1'b0;
      rxd      = 1'b1;
      br_cfg   = 2'd0;
      seed_val = $urandom(32'h7875_4567);
      repeat (5) @(negedge clk_100mhz_buf);
      rst_n = 1'b1;
      check_value("reset state", ST_IDLE, state);
      check_value("reset txd", 1'b1, txd);
      check_heartbeat(10 * (1 << HEARTBEAT_BIT));

      for (cfg = 0; cfg < 4; cfg++) begin
         br_cfg = 2'(cfg);
         repeat (4) @(negedge clk_100mhz_buf);
         written.delete();
         for (i = 0; i < NUM_WRITES; i++) begin
            addr = mem_addr_t'($urandom);
            write_word(addr, {$urandom, $urandom});
            written.push_back(addr);
         end
         for (i = 0; i < NUM_WRITES; i++) begin
            read_check(written[i], "readback");
         end

         // Same address twice, the second word must win
         addr = written[0];
         write_word(addr, {$urandom, $urandom});
         write_word(addr, {$urandom, $urandom});
         read_check(addr, "overwrite");

         for (i = 0; i < NUM_IGNORED; i++) begin
            do begin
               junk = byte_t'($urandom);
            end while (junk == CMD_WRITE || junk == CMD_READ);
            send_ignored(junk);
         end
         read_check(written[NUM_WRITES-1], "read after ignored bytes");
      end

      $display("Simulation PASSED");
      $finish;
   end

   // Forty bit periods per frame at the slowest rate, plus margin
   initial begin
      longint limit_ns;
      limit_ns = longint'(NUM_FRAMES) * 40 * bit_period(BAUD_BASE, 2'd0) * 10 + 100000;
      #(limit_ns);
      $display("Timeout, the test sequence did not finish in the expected time");
      $display("Simulation FAILED");
      $fatal(1);
   end

endmodule

// File: verilog/looper_tester.sv
`timescale 1ns/1ps

module looper_tester #(
   parameter int unsigned BAUD_BASE     = 651,
   parameter int unsigned HEARTBEAT_BIT = 21
) (
   input  logic                   clk_100mhz_buf,
   input  logic                   rst_n,
   input  logic                   rxd,
   input  logic [1:0]             br_cfg,
   output logic                   txd,
   output tester_pkg::mmu_state_t state,
   output logic                   gpio_led_1
);

   import tester_pkg::*;

   byte_t                rx_data;
   logic                 rx_valid;
   byte_t                tx_data;
   logic                 tx_start;
   logic                 tx_busy;
   logic                 mem_enb;
   logic                 mem_web;
   mem_addr_t            mem_addrb;
   word_t                mem_dinb;
   word_t                mem_doutb;
   logic [HEARTBEAT_BIT:0] hb_cnt;

   //////////////////////////////////////////////////////////////////////
   // Heartbeat
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_100mhz_buf or negedge rst_n) begin
      if (!rst_n) begin
         hb_cnt     <= '0;
         gpio_led_1 <= 1'b0;
      end else begin
         hb_cnt     <= hb_cnt + 1'b1;
         gpio_led_1 <= hb_cnt[HEARTBEAT_BIT];
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Serial link, decoder and program memory
   //////////////////////////////////////////////////////////////////////

   uart_rx #(
      .BAUD_BASE(BAUD_BASE)
   ) i_uart_rx (
      .clk_100mhz_buf(clk_100mhz_buf),
      .rst_n         (rst_n),
      .rxd           (rxd),
      .br_cfg        (br_cfg),
      .rx_data       (rx_data),
      .rx_valid      (rx_valid)
   );

   uart_tx #(
      .BAUD_BASE(BAUD_BASE)
   ) i_uart_tx (
      .clk_100mhz_buf(clk_100mhz_buf),
      .rst_n         (rst_n),
      .br_cfg        (br_cfg),
      .tx_start      (tx_start),
      .tx_data       (tx_data),
      .txd           (txd),
      .tx_busy       (tx_busy)
   );

   mmu i_mmu (
      .clk_100mhz_buf(clk_100mhz_buf),
      .rst_n         (rst_n),
      .rx_data       (rx_data),
      .rx_valid      (rx_valid),
      .tx_busy       (tx_busy),
      .doutb         (mem_doutb),
      .tx_start      (tx_start),
      .tx_data       (tx_data),
      .enb           (mem_enb),
      .web           (mem_web),
      .addrb         (mem_addrb),
      .dinb          (mem_dinb),
      .state         (state)
   );

   program_mem i_program_mem (
      .clk_100mhz_buf(clk_100mhz_buf),
      .enb           (mem_enb),
      .web           (mem_web),
      .addrb         (mem_addrb),
      .dinb          (mem_dinb),
      .doutb         (mem_doutb)
   );

endmodule

// File: verilog/mmu.sv
`timescale 1ns/1ps

module mmu (
   input  logic                   clk_100mhz_buf,
   input  logic                   rst_n,
   input  tester_pkg::byte_t      rx_data,
   input  logic                   rx_valid,
   input  logic                   tx_busy,
   input  tester_pkg::word_t      doutb,
   output logic                   tx_start,
   output tester_pkg::byte_t      tx_data,
   output logic                   enb,
   output logic                   web,
   output tester_pkg::mem_addr_t  addrb,
   output tester_pkg::word_t      dinb,
   output tester_pkg::mmu_state_t state
);

   import tester_pkg::*;

   logic       is_read;
   // Low in the enable cycle of a read, high while doutb settles
   logic       rd_pending;
   logic [3:0] byte_cnt;
   logic       last_data;
   logic       send_done;
   word_t      word_reg;

   assign last_data = (byte_cnt == 4'(WORD_BYTES - 1));
   assign send_done = (byte_cnt == 4'(WORD_BYTES));

   //////////////////////////////////////////////////////////////////////
   // Memory port and serial handshake
   //////////////////////////////////////////////////////////////////////

   assign enb  = (state == ST_WRITE) || (state == ST_READ && !rd_pending);
   assign web  = (state == ST_WRITE);
   assign dinb = word_reg;

   // Transmitter raises busy the next cycle, so this is a single pulse
   assign tx_start = (state == ST_SEND) && !tx_busy && !send_done;
   assign tx_data  = word_reg[63:56];

   //////////////////////////////////////////////////////////////////////
   // Command FSM
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_100mhz_buf or negedge rst_n) begin
      if (!rst_n) begin
         state      <= ST_IDLE;
         is_read    <= 1'b0;
         rd_pending <= 1'b0;
         byte_cnt   <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (rx_valid && rx_data == CMD_WRITE) begin
                  is_read <= 1'b0;
                  state   <= ST_ADDR_HI;
               end else if (rx_valid && rx_data == CMD_READ) begin
                  is_read <= 1'b1;
                  state   <= ST_ADDR_HI;
               end
            end
            ST_ADDR_HI: begin
               if (rx_valid) begin
                  state <= ST_ADDR_LO;
               end
            end
            ST_ADDR_LO: begin
               if (rx_valid) begin
                  byte_cnt <= '0;
                  state    <= is_read ? ST_READ : ST_DATA;
               end
            end
            ST_DATA: begin
               if (rx_valid) begin
                  byte_cnt <= byte_cnt + 4'd1;
                  if (last_data) begin
                     state <= ST_WRITE;
                  end
               end
            end
            ST_WRITE: state <= ST_IDLE;
            ST_READ: begin
               rd_pending <= !rd_pending;
               if (rd_pending) begin
                  state <= ST_SEND;
               end
            end
            ST_SEND: begin
               if (tx_start) begin
                  byte_cnt <= byte_cnt + 4'd1;
               end else if (send_done && !tx_busy) begin
                  state <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Address and word assembly, MSB first in both directions
   always_ff @(posedge clk_100mhz_buf) begin
      case (state)
         ST_ADDR_HI: begin
            // Top two address bits are dropped
            if (rx_valid) begin
               addrb[13:8] <= rx_data[5:0];
            end
         end
         ST_ADDR_LO: begin
            if (rx_valid) begin
               addrb[7:0] <= rx_data;
            end
         end
         ST_DATA: begin
            if (rx_valid) begin
               word_reg <= {word_reg[55:0], rx_data};
            end
         end
         ST_READ: begin
            if (rd_pending) begin
               word_reg <= doutb;
            end
         end
         ST_SEND: begin
            if (tx_start) begin
               word_reg <= {word_reg[55:0], 8'h00};
            end
         end
         default: ;
      endcase
   end

endmodule

// File: verilog/program_mem.sv
`timescale 1ns/1ps

module program_mem (
   input  logic                  clk_100mhz_buf,
   input  logic                  enb,
   input  logic                  web,
   input  tester_pkg::mem_addr_t addrb,
   input  tester_pkg::word_t     dinb,
   output tester_pkg::word_t     doutb
);

   import tester_pkg::*;

   localparam int DEPTH = 2 ** $bits(mem_addr_t);

   word_t mem [DEPTH];

   // Read data stays put until the next read access
   always_ff @(posedge clk_100mhz_buf) begin
      if (enb) begin
         if (web) begin
            mem[addrb] <= dinb;
         end else begin
            doutb <= mem[addrb];
         end
      end
   end

endmodule

// File: verilog/tester_pkg.sv
package tester_pkg;

   // Widths shared by the serial link and the program memory
   typedef logic [7:0]  byte_t;
   typedef logic [63:0] word_t;
   typedef logic [13:0] mem_addr_t;

   // Command decoder states, shown on the board LEDs
   typedef enum logic [3:0] {
      ST_IDLE    = 4'd0,
      ST_ADDR_HI,
      ST_ADDR_LO,
      ST_DATA,
      ST_WRITE,
      ST_READ,
      ST_SEND
   } mmu_state_t;

   // ASCII W and R
   localparam byte_t CMD_WRITE = 8'h57;
   localparam byte_t CMD_READ  = 8'h52;

   localparam int WORD_BYTES = 8;

   // Clocks per serial bit, br_cfg 3 is the fastest rate
   function automatic int unsigned bit_period(input int unsigned base,
                                              input logic [1:0]  br_cfg);
      case (br_cfg)
         2'd0:    return base * 8;
         2'd1:    return base * 4;
         2'd2:    return base * 2;
         default: return base;
      endcase
   endfunction

endpackage

// File: verilog/uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
   parameter int unsigned BAUD_BASE = 651
) (
   input  logic              clk_100mhz_buf,
   input  logic              rst_n,
   input  logic              rxd,
   input  logic [1:0]        br_cfg,
   output tester_pkg::byte_t rx_data,
   output logic              rx_valid
);

   import tester_pkg::*;

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_t;

   rx_state_t   rx_state;
   logic        rxd_meta;
   logic        rxd_sync;
   logic        rxd_prev;
   logic [15:0] period;
   logic [15:0] baud_cnt;
   logic [2:0]  bit_idx;
   logic        sample;
   byte_t       shift_reg;

   assign period  = 16'(bit_period(BAUD_BASE, br_cfg));
   assign sample  = (baud_cnt == '0);
   assign rx_data = shift_reg;

   // Two flop synchronizer, plus one more stage for edge detect
   always_ff @(posedge clk_100mhz_buf or negedge rst_n) begin
      if (!rst_n) begin
         rxd_meta <= 1'b1;
         rxd_sync <= 1'b1;
         rxd_prev <= 1'b1;
      end else begin
         rxd_meta <= rxd;
         rxd_sync <= rxd_meta;
         rxd_prev <= rxd_sync;
      end
   end

   always_ff @(posedge clk_100mhz_buf or negedge rst_n) begin
      if (!rst_n) begin
         rx_state <= RX_IDLE;
         baud_cnt <= '0;
         bit_idx  <= '0;
         rx_valid <= 1'b0;
      end else begin
         rx_valid <= 1'b0;
         if (rx_state != RX_IDLE && !sample) begin
            baud_cnt <= baud_cnt - 16'd1;
         end
         case (rx_state)
            RX_IDLE: begin
               // Half a bit to land in the middle of the start bit
               if (rxd_prev && !rxd_sync) begin
                  baud_cnt <= (period >> 1) - 16'd1;
                  rx_state <= RX_START;
               end
            end
            RX_START: begin
               if (sample) begin
                  baud_cnt <= period - 16'd1;
                  bit_idx  <= '0;
                  // A high line here was only a glitch
                  rx_state <= rxd_sync ? RX_IDLE : RX_DATA;
               end
            end
            RX_DATA: begin
               if (sample) begin
                  baud_cnt <= period - 16'd1;
                  bit_idx  <= bit_idx + 3'd1;
                  if (bit_idx == 3'd7) begin
                     rx_state <= RX_STOP;
                  end
               end
            end
            RX_STOP: begin
               if (sample) begin
                  // Framing error drops the byte
                  rx_valid <= rxd_sync;
                  rx_state <= RX_IDLE;
               end
            end
            default: rx_state <= RX_IDLE;
         endcase
      end
   end

   // LSB arrives first
   always_ff @(posedge clk_100mhz_buf) begin
      if (rx_state == RX_DATA && sample) begin
         shift_reg <= {rxd_sync, shift_reg[7:1]};
      end
   end

endmodule

// File: verilog/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
   parameter int unsigned BAUD_BASE = 651
) (
   input  logic              clk_100mhz_buf,
   input  logic              rst_n,
   input  logic [1:0]        br_cfg,
   input  logic              tx_start,
   input  tester_pkg::byte_t tx_data,
   output logic              txd,
   output logic              tx_busy
);

   import tester_pkg::*;

   logic [15:0] period;
   logic [15:0] baud_cnt;
   logic [3:0]  bits_left;
   logic        bit_end;
   logic        load;
   logic        shift;
   // Data bits followed by the stop bit
   logic [8:0]  shifter;

   assign period  = 16'(bit_period(BAUD_BASE, br_cfg));
   assign bit_end = (baud_cnt == '0);
   assign load    = !tx_busy && tx_start;
   assign shift   = tx_busy && bit_end && (bits_left != '0);

   always_ff @(posedge clk_100mhz_buf or negedge rst_n) begin
      if (!rst_n) begin
         txd       <= 1'b1;
         tx_busy   <= 1'b0;
         baud_cnt  <= '0;
         bits_left <= '0;
      end else if (load) begin
         // Start bit goes out right away
         txd       <= 1'b0;
         tx_busy   <= 1'b1;
         baud_cnt  <= period - 16'd1;
         bits_left <= 4'd9;
      end else if (tx_busy) begin
         if (!bit_end) begin
            baud_cnt <= baud_cnt - 16'd1;
         end else if (bits_left == '0) begin
            // Stop bit has run its full length
            tx_busy <= 1'b0;
         end else begin
            txd       <= shifter[0];
            bits_left <= bits_left - 4'd1;
            baud_cnt  <= period - 16'd1;
         end
      end
   end

   always_ff @(posedge clk_100mhz_buf) begin
      if (load) begin
         shifter <= {1'b1, tx_data};
      end else if (shift) begin
         shifter <= {1'b1, shifter[8:1]};
      end
   end

endmodule
